//--- Makefile
# Verilator build and run of the instruction cache testbench

OBJ_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module icache_tb --Mdir $(OBJ_DIR) -o icache_sim
	@out="$$(./$(OBJ_DIR)/icache_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJ_DIR)

//--- common/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

////////////////////////////////////////
// Cache geometry
////////////////////////////////////////

// Sets and ways, one data bank per way
`define ICACHE_SETS 256
`define ICACHE_ASSOC 4

// Block and bank widths in bits
`define ICACHE_BLOCK_WIDTH 256
`define ICACHE_BANK_WIDTH 64

`define ICACHE_INSTR_WIDTH 32

////////////////////////////////////////
// Address widths
////////////////////////////////////////

`define ICACHE_VADDR_WIDTH 39
`define ICACHE_PTAG_WIDTH 28
`define ICACHE_PAGE_OFFSET_WIDTH 12

`endif

//--- common/icache_pkg.sv
`include "icache_config.svh"

package icache_pkg;

  ////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////

  localparam int INDEX_W = $clog2(`ICACHE_SETS);
  localparam int WAY_W = $clog2(`ICACHE_ASSOC);
  localparam int WORD_W = $clog2(`ICACHE_BANK_WIDTH / `ICACHE_INSTR_WIDTH);
  localparam int BYTE_W = $clog2(`ICACHE_INSTR_WIDTH / 8);
  localparam int PADDR_W = `ICACHE_PTAG_WIDTH + `ICACHE_PAGE_OFFSET_WIDTH;

  typedef logic [WAY_W-1:0] way_id_t;

  // Offset fields of a fetch address, low bits last
  typedef struct packed {
    logic [INDEX_W-1:0] index;
    way_id_t            bank;
    logic [WORD_W-1:0]  word;
    logic [BYTE_W-1:0]  byte_off;
  } fetch_addr_s;

  typedef struct packed {
    logic                          valid;
    logic [`ICACHE_PTAG_WIDTH-1:0] ptag;
  } tag_info_s;

  typedef struct packed {
    logic [INDEX_W-1:0] index;
    way_id_t            way;
    tag_info_s          info;
  } tag_mem_pkt_s;

  // Whole block, bank 0 in the low bits
  typedef struct packed {
    logic [INDEX_W-1:0]             index;
    way_id_t                        way;
    logic [`ICACHE_BLOCK_WIDTH-1:0] data;
  } data_mem_pkt_s;

  typedef struct packed {
    logic                          v;
    logic                          w;
    logic [INDEX_W-1:0]            index;
    way_id_t                       bank;
    logic [`ICACHE_BANK_WIDTH-1:0] data;
  } bank_cmd_s;

  // Carried from tag lookup into tag verify
  typedef struct packed {
    logic                       v;
    logic [PADDR_W-1:0]         paddr;
    logic [INDEX_W-1:0]         index;
    logic [`ICACHE_ASSOC-1:0]   hit;
    logic [`ICACHE_ASSOC-1:0]   bank_oh;
  } tl_carry_s;

  typedef struct packed {
    logic [PADDR_W-1:0] addr;
  } cache_req_s;

  typedef struct packed {
    way_id_t way;
  } req_metadata_s;

endpackage

//--- data_bank/icache_data_bank.sv
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_data_bank
  (input                                   clk_i
   , input                                 reset_i
   , input  icache_pkg::bank_cmd_s         cmd_i
   , output logic [`ICACHE_BANK_WIDTH-1:0] data_o
   );

  import icache_pkg::*;

  localparam int DEPTH = `ICACHE_SETS * `ICACHE_ASSOC;

  logic [`ICACHE_BANK_WIDTH-1:0] mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]      addr;

  // Index high, bank offset low
  assign addr = {cmd_i.index, cmd_i.bank};

  always_ff @(posedge clk_i)
  begin
    if (cmd_i.v && cmd_i.w)
      mem[addr] <= cmd_i.data;
  end

  // Read data holds until the next read
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      data_o <= '0;
    else if (cmd_i.v && !cmd_i.w)
      data_o <= mem[addr];
  end

endmodule

//--- lookup/icache_lookup.sv
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_lookup
  (input                                clk_i
   , input                              reset_i
   , input                              fetch_v_i
   , input  [`ICACHE_VADDR_WIDTH-1:0]   fetch_vaddr_i
   , output logic                       ready_o
   , input  [`ICACHE_PTAG_WIDTH-1:0]    ptag_i
   , input                              ptag_v_i
   , input  icache_pkg::tag_mem_pkt_s   tag_pkt_i
   , input                              tag_pkt_v_i
   , output logic                       tag_pkt_yumi_o
   , input  icache_pkg::data_mem_pkt_s  data_pkt_i
   , input                              data_pkt_v_i
   , output logic                       data_pkt_yumi_o
   , input                              stage_busy_i
   , output icache_pkg::bank_cmd_s [`ICACHE_ASSOC-1:0] bank_cmd_o
   , output icache_pkg::tl_carry_s      tl_carry_o
   );

  import icache_pkg::*;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  fetch_addr_s vaddr;
  assign vaddr = fetch_addr_s'(fetch_vaddr_i[$bits(fetch_addr_s)-1:0]);

  assign ready_o = ~stage_busy_i;
  wire accept = fetch_v_i & ready_o;

  // Packets only get the memories in fetch-free cycles
  assign tag_pkt_yumi_o  = tag_pkt_v_i & ~accept;
  assign data_pkt_yumi_o = data_pkt_v_i & ~accept;

  ////////////////////////////////////////
  // Tag memory
  ////////////////////////////////////////

  logic [`ICACHE_PTAG_WIDTH-1:0] tag_mem [`ICACHE_SETS][`ICACHE_ASSOC];
  logic [`ICACHE_ASSOC-1:0]      valid_mem [`ICACHE_SETS];
  logic [`ICACHE_PTAG_WIDTH-1:0] tag_rd_r [`ICACHE_ASSOC];
  logic [`ICACHE_ASSOC-1:0]      valid_rd_r;

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      tag_rd_r <= tag_mem[vaddr.index];
    end
    else if (tag_pkt_yumi_o)
    begin
      tag_mem[tag_pkt_i.index][tag_pkt_i.way] <= tag_pkt_i.info.ptag;
    end
  end

  // Valid bits clear on reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
        valid_mem[s] <= '0;
      valid_rd_r <= '0;
    end
    else if (accept)
      valid_rd_r <= valid_mem[vaddr.index];
    else if (tag_pkt_yumi_o)
      valid_mem[tag_pkt_i.index][tag_pkt_i.way] <= tag_pkt_i.info.valid;
  end

  ////////////////////////////////////////
  // Tag lookup stage
  ////////////////////////////////////////

  logic        tl_v_r;
  fetch_addr_s tl_addr_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_v_r <= 1'b0;
    else
      tl_v_r <= accept;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      tl_addr_r <= vaddr;
  end

  logic [`ICACHE_ASSOC-1:0] hit_tl;
  always_comb
  begin
    for (int i = 0; i < `ICACHE_ASSOC; i++)
      hit_tl[i] = valid_rd_r[i] & (tag_rd_r[i] == ptag_i);
  end

  // Stage valid only with a tag in time and no stall
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      tl_carry_o.v <= 1'b0;
    else
      tl_carry_o.v <= tl_v_r & ptag_v_i & ~stage_busy_i;
  end

  always_ff @(posedge clk_i)
  begin
    tl_carry_o.paddr   <= {ptag_i, tl_addr_r[`ICACHE_PAGE_OFFSET_WIDTH-1:0]};
    tl_carry_o.index   <= tl_addr_r.index;
    tl_carry_o.hit     <= hit_tl;
    tl_carry_o.bank_oh <= `ICACHE_ASSOC'(1) << tl_addr_r.bank;
  end

  ////////////////////////////////////////
  // Bank steering
  ////////////////////////////////////////

  // Bank i of way w holds block chunk i-w
  always_comb
  begin
    for (int i = 0; i < `ICACHE_ASSOC; i++)
    begin
      bank_cmd_o[i].v     = accept | data_pkt_yumi_o;
      bank_cmd_o[i].w     = ~accept;
      bank_cmd_o[i].index = accept ? vaddr.index : data_pkt_i.index;
      bank_cmd_o[i].bank  = accept ? vaddr.bank : way_id_t'(way_id_t'(i) - data_pkt_i.way);
      bank_cmd_o[i].data  =
        data_pkt_i.data[`ICACHE_BANK_WIDTH*way_id_t'(way_id_t'(i) - data_pkt_i.way)
                        +: `ICACHE_BANK_WIDTH];
    end
  end

  // A packet passed over for a fetch stays offered unchanged
  a_tag_pkt_held : assert property (@(posedge clk_i) disable iff (reset_i)
    tag_pkt_v_i && !tag_pkt_yumi_o |=> tag_pkt_v_i && $stable(tag_pkt_i));
  a_data_pkt_held : assert property (@(posedge clk_i) disable iff (reset_i)
    data_pkt_v_i && !data_pkt_yumi_o |=> data_pkt_v_i && $stable(data_pkt_i));

endmodule

//--- tb.f
+incdir+common
+incdir+tests
common/icache_pkg.sv
data_bank/icache_data_bank.sv
lookup/icache_lookup.sv
verilog/icache_verify.sv
verilog/icache_top.sv
tests/icache_tb.sv

//--- tests/icache_tb_tasks.svh
`ifndef ICACHE_TB_TASKS_SVH
`define ICACHE_TB_TASKS_SVH

////////////////////////////////////////
// Stimulus and reference helpers
////////////////////////////////////////

// Taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [`ICACHE_BLOCK_WIDTH-1:0] random_block();
  logic [`ICACHE_BLOCK_WIDTH-1:0] blk;
  for (int i = 0; i < `ICACHE_BLOCK_WIDTH; i++)
  begin
    lfsr_state = lfsr_next(lfsr_state);
    blk[i] = lfsr_state[0];
  end
  return blk;
endfunction

// Used way becomes the far side of each node on its path
function automatic void plru_touch(input int set, input int way);
  plru_root[set] = (way < 2);
  if (way < 2)
    plru_low[set] = (way == 0);
  else
    plru_high[set] = (way == 2);
endfunction

function automatic way_id_t plru_victim(input int set);
  if (plru_root[set])
    return plru_high[set] ? 2'd3 : 2'd2;
  return plru_low[set] ? 2'd1 : 2'd0;
endfunction

function automatic int ref_way(input fetch_addr_s a, input logic [`ICACHE_PTAG_WIDTH-1:0] ptag);
  for (int w = 0; w < `ICACHE_ASSOC; w++)
    if (ref_valid[a.index][w] && ref_tag[a.index][w] == ptag)
      return w;
  return -1;
endfunction

// Physical tag over the page offset, block offset cleared
function automatic cache_req_s block_request(input fetch_addr_s a,
                                             input logic [`ICACHE_PTAG_WIDTH-1:0] ptag);
  cache_req_s r;
  r.addr = {ptag, a[`ICACHE_PAGE_OFFSET_WIDTH-1:0]};
  r.addr[BLOCK_OFF_W-1:0] = '0;
  return r;
endfunction

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic check_flag(input string what, input logic got, input logic exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("[FAIL] %0t ns: %s: got %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic check_word(input string what, input logic [`ICACHE_INSTR_WIDTH-1:0] got,
                          input logic [`ICACHE_INSTR_WIDTH-1:0] exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
  end
endtask

task automatic check_req(input string what, input cache_req_s got, input cache_req_s exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("[FAIL] %0t ns: %s: got address %h, expected %h", $time, what, got.addr, exp.addr);
  end
endtask

task automatic check_meta(input string what, input req_metadata_s got, input req_metadata_s exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("[FAIL] %0t ns: %s: got way %0d, expected way %0d", $time, what, got.way, exp.way);
  end
endtask

task automatic report_test(input string name, input int errors_before);
  tests_run++;
  if (errors == errors_before)
    $display("%s: ok", name);
  else
  begin
    tests_failed++;
    $display("%s: %0d errors", name, errors - errors_before);
  end
endtask

////////////////////////////////////////
// Drive tasks, all entered on a falling edge
////////////////////////////////////////

task automatic wait_yumi(input bit data_side, input string what);
  bit seen;
  seen = 1'b0;
  for (int n = 0; n < YUMI_LIMIT && !seen; n++)
  begin
    #1;
    seen = data_side ? data_pkt_yumi_o : tag_pkt_yumi_o;
    @(negedge clk_i);
  end
  if (!seen)
  begin
    errors++;
    $display("Error: the %s was not accepted within %0d cycles", what, YUMI_LIMIT);
  end
endtask

task automatic write_tag(input int index, input int way,
                         input logic [`ICACHE_PTAG_WIDTH-1:0] ptag);
  tag_mem_pkt_s pkt;
  pkt.index = index[INDEX_W-1:0];
  pkt.way = way_id_t'(way);
  pkt.info.valid = 1'b1;
  pkt.info.ptag = ptag;
  tag_pkt_i = pkt;
  tag_pkt_v_i = 1'b1;
  wait_yumi(1'b0, "tag packet");
  tag_pkt_v_i = 1'b0;
  ref_tag[index][way] = ptag;
  ref_valid[index][way] = 1'b1;
endtask

task automatic write_block(input int index, input int way,
                           input logic [`ICACHE_BLOCK_WIDTH-1:0] blk);
  data_mem_pkt_s pkt;
  pkt.index = index[INDEX_W-1:0];
  pkt.way = way_id_t'(way);
  pkt.data = blk;
  data_pkt_i = pkt;
  data_pkt_v_i = 1'b1;
  wait_yumi(1'b1, "data packet");
  data_pkt_v_i = 1'b0;
  ref_block[index][way] = blk;
endtask

// Fetch, tag one cycle later, return on the result cycle
task automatic issue_fetch(input fetch_addr_s a, input logic [`ICACHE_PTAG_WIDTH-1:0] ptag);
  fetch_vaddr_i = `ICACHE_VADDR_WIDTH'(a);
  fetch_v_i = 1'b1;
  check_flag("ready at fetch", ready_o, 1'b1);
  @(negedge clk_i);
  fetch_v_i = 1'b0;
  ptag_i = ptag;
  ptag_v_i = 1'b1;
  check_flag("no data one cycle after fetch", data_v_o, 1'b0);
  check_flag("no miss one cycle after fetch", miss_v_o, 1'b0);
  @(negedge clk_i);
  ptag_v_i = 1'b0;
endtask

task automatic check_hit_result(input fetch_addr_s a, input logic [`ICACHE_PTAG_WIDTH-1:0] ptag);
  int way;
  logic [`ICACHE_INSTR_WIDTH-1:0] exp;
  way = ref_way(a, ptag);
  if (way < 0)
  begin
    errors++;
    $display("Error: no reference block for tag %h in set %h", ptag, a.index);
    return;
  end
  exp = ref_block[a.index][way][`ICACHE_INSTR_WIDTH*int'({a.bank, a.word})
                                +: `ICACHE_INSTR_WIDTH];
  check_flag("data valid on hit", data_v_o, 1'b1);
  check_flag("no miss on hit", miss_v_o, 1'b0);
  check_word("fetched word", data_o, exp);
  plru_touch(a.index, way);
endtask

task automatic expect_hit(input fetch_addr_s a, input logic [`ICACHE_PTAG_WIDTH-1:0] ptag);
  issue_fetch(a, ptag);
  check_hit_result(a, ptag);
endtask

// Engine side of a miss, entered on the miss cycle
task automatic serve_miss(input cache_req_s exp_req, input req_metadata_s exp_meta, input int hold);
  check_flag("miss valid", miss_v_o, 1'b1);
  check_flag("no data on miss", data_v_o, 1'b0);
  check_flag("request with miss", cache_req_v_o, 1'b1);
  check_flag("ready in miss cycle", ready_o, 1'b1);
  check_req("miss request", cache_req_o, exp_req);
  repeat (hold)
  begin
    @(negedge clk_i);
    check_flag("request held without yumi", cache_req_v_o, 1'b1);
    check_req("held request", cache_req_o, exp_req);
    check_flag("ready while request waits", ready_o, 1'b0);
  end
  cache_req_yumi_i = 1'b1;
  check_flag("metadata before yumi", cache_req_metadata_v_o, 1'b0);
  @(negedge clk_i);
  cache_req_yumi_i = 1'b0;
  check_flag("metadata after yumi", cache_req_metadata_v_o, 1'b1);
  check_meta("replacement way", cache_req_metadata_o, exp_meta);
  check_flag("request after yumi", cache_req_v_o, 1'b0);
  check_flag("ready before completion", ready_o, 1'b0);
  @(negedge clk_i);
  check_flag("metadata pulse length", cache_req_metadata_v_o, 1'b0);
  cache_req_complete_i = 1'b1;
  @(negedge clk_i);
  cache_req_complete_i = 1'b0;
  check_flag("ready after completion", ready_o, 1'b1);
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic test_cold_miss();
  fetch_addr_s a;
  cache_req_s exp_req;
  req_metadata_s exp_meta;
  check_flag("data valid after reset", data_v_o, 1'b0);
  check_flag("miss after reset", miss_v_o, 1'b0);
  check_flag("request after reset", cache_req_v_o, 1'b0);
  check_flag("metadata after reset", cache_req_metadata_v_o, 1'b0);
  check_flag("tag yumi after reset", tag_pkt_yumi_o, 1'b0);
  check_flag("data yumi after reset", data_pkt_yumi_o, 1'b0);
  check_flag("ready after reset", ready_o, 1'b1);
  a = '0;
  a.index = COLD_SET;
  a.bank = 2'd1;
  a.word = 1'b1;
  issue_fetch(a, COLD_PTAG);
  exp_req = block_request(a, COLD_PTAG);
  exp_meta.way = plru_victim(COLD_SET);
  serve_miss(exp_req, exp_meta, 3);
endtask

task automatic test_fill_hit();
  fetch_addr_s a;
  way_id_t way;
  way = plru_victim(COLD_SET);
  write_tag(COLD_SET, way, COLD_PTAG);
  write_block(COLD_SET, way, random_block());
  a = '0;
  a.index = COLD_SET;
  for (int w = 0; w < WORDS; w++)
  begin
    {a.bank, a.word} = 3'(w);
    expect_hit(a, COLD_PTAG);
  end
endtask

task automatic test_way_interleave();
  fetch_addr_s a;
  for (int w = 0; w < `ICACHE_ASSOC; w++)
  begin
    write_tag(INTERLEAVE_SET, w, INTERLEAVE_PTAG + 28'(w));
    write_block(INTERLEAVE_SET, w, random_block());
  end
  a = '0;
  a.index = INTERLEAVE_SET;
  for (int w = 0; w < `ICACHE_ASSOC; w++)
    for (int k = 0; k < WORDS; k++)
    begin
      {a.bank, a.word} = 3'(k);
      expect_hit(a, INTERLEAVE_PTAG + 28'(w));
    end
endtask

task automatic test_replacement();
  int order [3];
  fetch_addr_s a;
  cache_req_s exp_req;
  req_metadata_s exp_meta;
  order = '{3, 0, 2};
  foreach (order[i])
  begin
    write_tag(REPLACE_SET, order[i], REPLACE_PTAG + 28'(order[i]));
    write_block(REPLACE_SET, order[i], random_block());
  end
  a = '0;
  a.index = REPLACE_SET;
  foreach (order[i])
  begin
    a.bank = way_id_t'(i);
    expect_hit(a, REPLACE_PTAG + 28'(order[i]));
  end
  a.bank = 2'd3;
  issue_fetch(a, MISS_PTAG);
  exp_req = block_request(a, MISS_PTAG);
  exp_meta.way = plru_victim(REPLACE_SET);
  serve_miss(exp_req, exp_meta, 0);
endtask

// One fetch per cycle while a data packet waits for a free cycle
task automatic test_stream_pressure();
  fetch_addr_s addr [STREAM_LEN];
  logic [`ICACHE_PTAG_WIDTH-1:0] tag [STREAM_LEN];
  data_mem_pkt_s pkt;
  for (int k = 0; k < STREAM_LEN; k++)
  begin
    addr[k] = '0;
    addr[k].index = INTERLEAVE_SET;
    {addr[k].bank, addr[k].word} = 3'(3 * k);
    tag[k] = INTERLEAVE_PTAG + 28'(k % `ICACHE_ASSOC);
  end
  pkt.index = SPARE_SET;
  pkt.way = 2'd1;
  pkt.data = random_block();
  data_pkt_i = pkt;
  for (int k = 0; k < STREAM_LEN + 2; k++)
  begin
    data_pkt_v_i = (k <= STREAM_LEN);
    fetch_v_i = (k < STREAM_LEN);
    if (k < STREAM_LEN)
      fetch_vaddr_i = `ICACHE_VADDR_WIDTH'(addr[k]);
    ptag_v_i = (k >= 1 && k <= STREAM_LEN);
    if (k >= 1 && k <= STREAM_LEN)
      ptag_i = tag[k-1];
    #1;
    check_flag("data yumi only in a fetch-free cycle", data_pkt_yumi_o, k == STREAM_LEN);
    if (k >= 2)
      check_hit_result(addr[k-2], tag[k-2]);
    @(negedge clk_i);
  end
  ref_block[SPARE_SET][1] = pkt.data;
  cache_req_busy_i = 1'b1;
  #1;
  check_flag("ready with engine busy", ready_o, 1'b0);
  @(negedge clk_i);
  cache_req_busy_i = 1'b0;
  #1;
  check_flag("ready once engine is free", ready_o, 1'b1);
  @(negedge clk_i);
endtask

`endif

//--- tests/icache_tb.sv
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_tb;

  import icache_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int WORDS = `ICACHE_BLOCK_WIDTH / `ICACHE_INSTR_WIDTH;
  localparam int BLOCK_OFF_W = WAY_W + WORD_W + BYTE_W;
  localparam int YUMI_LIMIT = 20;
  localparam int STREAM_LEN = 8;

  ////////////////////////////////////////
  // Test constants
  ////////////////////////////////////////

  localparam logic [INDEX_W-1:0] COLD_SET = 8'h3c;
  localparam logic [INDEX_W-1:0] INTERLEAVE_SET = 8'h5a;
  localparam logic [INDEX_W-1:0] REPLACE_SET = 8'h91;
  localparam logic [INDEX_W-1:0] SPARE_SET = 8'h07;
  localparam logic [`ICACHE_PTAG_WIDTH-1:0] COLD_PTAG = 28'h0abc123;
  localparam logic [`ICACHE_PTAG_WIDTH-1:0] INTERLEAVE_PTAG = 28'h7e51000;
  localparam logic [`ICACHE_PTAG_WIDTH-1:0] REPLACE_PTAG = 28'h2200000;
  localparam logic [`ICACHE_PTAG_WIDTH-1:0] MISS_PTAG = 28'h2bad000;

  // Cycle budget per test, summed for the watchdog
  localparam int COLD_MISS_CYCLES = 30;
  localparam int FILL_HIT_CYCLES = 40;
  localparam int INTERLEAVE_CYCLES = 100;
  localparam int REPLACE_CYCLES = 40;
  localparam int STREAM_CYCLES = 30;
  localparam int MARGIN_CYCLES = 50;
  localparam int WATCHDOG_CYCLES = 2 + COLD_MISS_CYCLES + FILL_HIT_CYCLES
    + INTERLEAVE_CYCLES + REPLACE_CYCLES + STREAM_CYCLES + MARGIN_CYCLES;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic                            clk_i;
  logic                            reset_i;
  logic                            fetch_v_i;
  logic [`ICACHE_VADDR_WIDTH-1:0]  fetch_vaddr_i;
  logic                            ready_o;
  logic [`ICACHE_PTAG_WIDTH-1:0]   ptag_i;
  logic                            ptag_v_i;
  logic [`ICACHE_INSTR_WIDTH-1:0]  data_o;
  logic                            data_v_o;
  logic                            miss_v_o;
  cache_req_s                      cache_req_o;
  logic                            cache_req_v_o;
  logic                            cache_req_yumi_i;
  logic                            cache_req_busy_i;
  logic                            cache_req_complete_i;
  req_metadata_s                   cache_req_metadata_o;
  logic                            cache_req_metadata_v_o;
  tag_mem_pkt_s                    tag_pkt_i;
  logic                            tag_pkt_v_i;
  logic                            tag_pkt_yumi_o;
  data_mem_pkt_s                   data_pkt_i;
  logic                            data_pkt_v_i;
  logic                            data_pkt_yumi_o;

  icache_top icache_top_i (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  ////////////////////////////////////////
  // Engine model storage
  ////////////////////////////////////////

  logic [`ICACHE_BLOCK_WIDTH-1:0] ref_block [`ICACHE_SETS][`ICACHE_ASSOC];
  logic [`ICACHE_PTAG_WIDTH-1:0]  ref_tag [`ICACHE_SETS][`ICACHE_ASSOC];
  bit                             ref_valid [`ICACHE_SETS][`ICACHE_ASSOC];

  // Tree bits, root picks the half and the leaves a way in it
  bit plru_root [`ICACHE_SETS];
  bit plru_low [`ICACHE_SETS];
  bit plru_high [`ICACHE_SETS];

  logic [31:0] lfsr_state = 32'h6d1f_afd5;
  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;

  `include "icache_tb_tasks.svh"

  initial
  begin
    int errors_before;
    clk_i = 1'b0;
    reset_i = 1'b1;
    fetch_v_i = 1'b0;
    fetch_vaddr_i = '0;
    ptag_i = '0;
    ptag_v_i = 1'b0;
    cache_req_yumi_i = 1'b0;
    cache_req_busy_i = 1'b0;
    cache_req_complete_i = 1'b0;
    tag_pkt_i = '0;
    tag_pkt_v_i = 1'b0;
    data_pkt_i = '0;
    data_pkt_v_i = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    errors_before = errors;
    test_cold_miss();
    report_test("cold miss", errors_before);
    errors_before = errors;
    test_fill_hit();
    report_test("fill then hit", errors_before);
    errors_before = errors;
    test_way_interleave();
    report_test("way interleave", errors_before);
    errors_before = errors;
    test_replacement();
    report_test("replacement", errors_before);
    errors_before = errors;
    test_stream_pressure();
    report_test("back-to-back and pressure", errors_before);

    $display("%0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- verilog/icache_top.sv
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_top
  (input                                   clk_i
   , input                                 reset_i
   , input                                 fetch_v_i
   , input  [`ICACHE_VADDR_WIDTH-1:0]      fetch_vaddr_i
   , output logic                          ready_o
   , input  [`ICACHE_PTAG_WIDTH-1:0]       ptag_i
   , input                                 ptag_v_i
   , output logic [`ICACHE_INSTR_WIDTH-1:0] data_o
   , output logic                          data_v_o
   , output logic                          miss_v_o
   , output icache_pkg::cache_req_s        cache_req_o
   , output logic                          cache_req_v_o
   , input                                 cache_req_yumi_i
   , input                                 cache_req_busy_i
   , input                                 cache_req_complete_i
   , output icache_pkg::req_metadata_s     cache_req_metadata_o
   , output logic                          cache_req_metadata_v_o
   , input  icache_pkg::tag_mem_pkt_s      tag_pkt_i
   , input                                 tag_pkt_v_i
   , output logic                          tag_pkt_yumi_o
   , input  icache_pkg::data_mem_pkt_s     data_pkt_i
   , input                                 data_pkt_v_i
   , output logic                          data_pkt_yumi_o
   );

  import icache_pkg::*;

  bank_cmd_s [`ICACHE_ASSOC-1:0]               bank_cmd;
  logic [`ICACHE_ASSOC-1:0][`ICACHE_BANK_WIDTH-1:0] bank_data;
  tl_carry_s tl_carry;
  logic      verify_busy;

  // Engine busy also holds off new fetches
  wire stage_busy = verify_busy | cache_req_busy_i;

  icache_lookup lookup_i
    (.clk_i, .reset_i, .fetch_v_i, .fetch_vaddr_i, .ready_o, .ptag_i, .ptag_v_i
     ,.tag_pkt_i, .tag_pkt_v_i, .tag_pkt_yumi_o
     ,.data_pkt_i, .data_pkt_v_i, .data_pkt_yumi_o
     ,.stage_busy_i(stage_busy)
     ,.bank_cmd_o(bank_cmd)
     ,.tl_carry_o(tl_carry)
     );

  for (genvar i = 0; i < `ICACHE_ASSOC; i++)
  begin : g_bank
    icache_data_bank bank_i
      (.clk_i, .reset_i
       ,.cmd_i(bank_cmd[i])
       ,.data_o(bank_data[i])
       );
  end

  icache_verify verify_i
    (.clk_i, .reset_i
     ,.tl_carry_i(tl_carry)
     ,.bank_data_i(bank_data)
     ,.data_o, .data_v_o, .miss_v_o
     ,.cache_req_o, .cache_req_v_o, .cache_req_yumi_i, .cache_req_complete_i
     ,.cache_req_metadata_o, .cache_req_metadata_v_o
     ,.stage_busy_o(verify_busy)
     );

endmodule

//--- verilog/icache_verify.sv
`timescale 1ns/100ps
`include "icache_config.svh"

module icache_verify
  (input                                   clk_i
   , input                                 reset_i
   , input  icache_pkg::tl_carry_s         tl_carry_i
   , input  [`ICACHE_ASSOC-1:0][`ICACHE_BANK_WIDTH-1:0] bank_data_i
   , output logic [`ICACHE_INSTR_WIDTH-1:0] data_o
   , output logic                          data_v_o
   , output logic                          miss_v_o
   , output icache_pkg::cache_req_s        cache_req_o
   , output logic                          cache_req_v_o
   , input                                 cache_req_yumi_i
   , input                                 cache_req_complete_i
   , output icache_pkg::req_metadata_s     cache_req_metadata_o
   , output logic                          cache_req_metadata_v_o
   , output logic                          stage_busy_o
   );

  import icache_pkg::*;

  typedef enum logic [1:0] {ST_READY, ST_REQ, ST_MISS} state_e;
  state_e state_r, state_n;

  ////////////////////////////////////////
  // Data selection
  ////////////////////////////////////////

  // Banks answer one cycle after the read, kept here for verify
  logic [`ICACHE_ASSOC-1:0][`ICACHE_BANK_WIDTH-1:0] ld_data_r;
  always_ff @(posedge clk_i)
  begin
    ld_data_r <= bank_data_i;
  end

  // One-hot sum of hit way and bank offset
  logic [`ICACHE_ASSOC-1:0]      bank_sel;
  logic [`ICACHE_BANK_WIDTH-1:0] bank_word;
  way_id_t                       hit_way;
  always_comb
  begin
    bank_sel  = '0;
    bank_word = '0;
    hit_way   = '0;
    for (int j = 0; j < `ICACHE_ASSOC; j++)
    begin
      if (tl_carry_i.hit[j])
        hit_way = way_id_t'(j);
      for (int k = 0; k < `ICACHE_ASSOC; k++)
        if (tl_carry_i.hit[j] && tl_carry_i.bank_oh[k])
          bank_sel[way_id_t'(j + k)] = 1'b1;
    end
    for (int i = 0; i < `ICACHE_ASSOC; i++)
      if (bank_sel[i])
        bank_word = ld_data_r[i];
  end

  wire word_sel = tl_carry_i.paddr[BYTE_W];
  assign data_o = bank_word[`ICACHE_INSTR_WIDTH*word_sel +: `ICACHE_INSTR_WIDTH];

  wire hit = |tl_carry_i.hit;
  assign data_v_o = tl_carry_i.v & (state_r == ST_READY) & hit;
  assign miss_v_o = tl_carry_i.v & (state_r == ST_READY) & ~hit;

  ////////////////////////////////////////
  // LRU store
  ////////////////////////////////////////

  // Bit 0 picks the pair, bits 1 and 2 the way within it
  logic [`ICACHE_ASSOC-2:0] lru_mem [`ICACHE_SETS];
  wire  [`ICACHE_ASSOC-2:0] lru = lru_mem[tl_carry_i.index];
  wire  way_id_t repl_way = {lru[0], lru[0] ? lru[2] : lru[1]};

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
        lru_mem[s] <= '0;
    end
    else if (data_v_o)
    begin
      lru_mem[tl_carry_i.index][0] <= ~hit_way[1];
      lru_mem[tl_carry_i.index][1 + hit_way[1]] <= ~hit_way[0];
    end
  end

  ////////////////////////////////////////
  // Miss request
  ////////////////////////////////////////

  cache_req_s req_r;
  way_id_t    repl_way_r;
  cache_req_s req_now;

  assign req_now.addr = {tl_carry_i.paddr[PADDR_W-1:WAY_W+WORD_W+BYTE_W],
                         {(WAY_W+WORD_W+BYTE_W){1'b0}}};

  always_ff @(posedge clk_i)
  begin
    if (miss_v_o)
    begin
      req_r      <= req_now;
      repl_way_r <= repl_way;
    end
  end

  assign cache_req_v_o = miss_v_o | (state_r == ST_REQ);
  assign cache_req_o   = (state_r == ST_READY) ? req_now : req_r;
  assign cache_req_metadata_o.way = repl_way_r;
  assign stage_busy_o  = (state_r != ST_READY);

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      ST_READY : if (miss_v_o) state_n = cache_req_yumi_i ? ST_MISS : ST_REQ;
      ST_REQ   : if (cache_req_yumi_i) state_n = ST_MISS;
      ST_MISS  : if (cache_req_complete_i) state_n = ST_READY;
      default  : state_n = ST_READY;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r                <= ST_READY;
      cache_req_metadata_v_o <= 1'b0;
    end
    else
    begin
      state_r                <= state_n;
      cache_req_metadata_v_o <= cache_req_yumi_i;
    end
  end

  // Request stays up and unchanged until the engine takes it
  a_req_held : assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_o && !cache_req_yumi_i |=> cache_req_v_o && $stable(cache_req_o));
  a_hit_onehot : assert property (@(posedge clk_i) disable iff (reset_i)
    tl_carry_i.v |-> $onehot0(tl_carry_i.hit));

endmodule
